//--- verilog/wr_engine_config.svh
`ifndef WR_ENGINE_CONFIG_SVH
`define WR_ENGINE_CONFIG_SVH

// ==========================================================
// Engine sizing
// ==========================================================

// Channels served by the round-robin arbiter
`define WR_NUM_CH       4

// AXI address and data widths
`define WR_ADDR_W       32
`define WR_DATA_W       32

// AXI ID width, channel number sits in the low bits
`define WR_ID_W         4

// Width of the buffer's data-available count per channel
`define WR_CNT_W        8

// Entries in the write-data order queue
// One burst per channel at most, so 4 entries never fill up
`define WR_ORDER_DEPTH  4

// ==========================================================
// Fixed AXI codes
// ==========================================================
`define WR_BURST_INCR   2'b01
`define WR_RESP_OKAY    2'b00

`endif

//--- verilog/wr_engine_pkg.sv
`include "wr_engine_config.svh"

package wr_engine_pkg;

    // Channel number, also the low bits of awid and bid
    typedef logic [$clog2(`WR_NUM_CH)-1:0] chan_id_t;

    // Burst length (awlen form) or a beat count within one burst
    typedef logic [7:0] beat_len_t;

    // Beats still left in a descriptor
    typedef logic [31:0] beat_total_t;

endpackage

//--- verilog/wr_req_filter.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_req_filter
    import wr_engine_pkg::*;
(
    input  logic [`WR_NUM_CH-1:0]               sched_valid,
    input  beat_total_t [`WR_NUM_CH-1:0]        sched_beats,
    input  beat_len_t                           cfg_xfer_len,
    input  logic [`WR_NUM_CH-1:0][`WR_CNT_W-1:0] data_avail,
    input  logic [`WR_NUM_CH-1:0]               busy,
    output logic [`WR_NUM_CH-1:0]               req,
    output beat_len_t [`WR_NUM_CH-1:0]          burst_len
);

    // One extra bit so a 256-beat burst still compares correctly
    localparam int CMP_W = `WR_CNT_W + 1;

    logic [`WR_NUM_CH-1:0] final_burst;
    logic [`WR_NUM_CH-1:0] has_data;

    always_comb begin
        for (int i = 0; i < `WR_NUM_CH; i++) begin
            // Remainder fits in one configured burst
            final_burst[i] = (sched_beats[i] != '0) &&
                             (sched_beats[i] <= beat_total_t'(cfg_xfer_len) + 32'd1);

            // Full configured burst, trimmed only on the descriptor's tail
            if (final_burst[i]) begin
                burst_len[i] = beat_len_t'(sched_beats[i] - 32'd1);
            end else begin
                burst_len[i] = cfg_xfer_len;
            end

            // Buffer already holds every beat of this burst
            has_data[i] = CMP_W'(data_avail[i]) >= (CMP_W'(burst_len[i]) + CMP_W'(1));

            // Tail burst may go ahead of its data, W stream waits on sram_valid
            req[i] = sched_valid[i] && (has_data[i] || final_burst[i]) && !busy[i];
        end
    end

endmodule

//--- verilog/wr_rr_arbiter.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_rr_arbiter
    import wr_engine_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`WR_NUM_CH-1:0] req,
    input  logic                  grant_ack,
    output logic                  grant_valid,
    output chan_id_t              grant_id
);

    // Last acknowledged channel, search starts just after it
    chan_id_t last_id;

    // Grant shown but not yet taken by the AW stage
    logic     locked;
    chan_id_t held_id;

    // Search results
    logic     found;
    chan_id_t pick;
    chan_id_t cand;

    // ==========================================================
    // Rotating priority search
    // ==========================================================
    always_comb begin
        found = 1'b0;
        pick  = last_id;
        cand  = last_id;
        for (int k = 1; k <= `WR_NUM_CH; k++) begin
            cand = chan_id_t'((int'(last_id) + k) % `WR_NUM_CH);
            if (!found && req[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // Pointer moves only on acknowledge, choice frozen until then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Channel 0 wins first after reset
            last_id <= chan_id_t'(`WR_NUM_CH - 1);
            locked  <= 1'b0;
            held_id <= '0;
        end else if (grant_ack) begin
            last_id <= grant_id;
            locked  <= 1'b0;
        end else if (grant_valid) begin
            locked  <= 1'b1;
            held_id <= grant_id;
        end
    end

    assign grant_valid = locked || found;
    assign grant_id    = locked ? held_id : pick;

endmodule

//--- verilog/wr_aw_issue.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_aw_issue
    import wr_engine_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  grant_valid,
    input  chan_id_t                              grant_id,
    input  beat_len_t [`WR_NUM_CH-1:0]            burst_len,
    input  logic [`WR_NUM_CH-1:0][`WR_ADDR_W-1:0] sched_addr,
    input  beat_total_t [`WR_NUM_CH-1:0]          sched_beats,
    input  logic                                  awready,
    output logic [`WR_ID_W-1:0]                   awid,
    output logic [`WR_ADDR_W-1:0]                 awaddr,
    output beat_len_t                             awlen,
    output logic [2:0]                            awsize,
    output logic [1:0]                            awburst,
    output logic                                  awvalid,
    output logic                                  grant_ack,
    output logic [`WR_NUM_CH-1:0]                 drain_req,
    output beat_len_t [`WR_NUM_CH-1:0]            drain_size,
    output logic [`WR_NUM_CH-1:0]                 sched_done,
    output beat_total_t [`WR_NUM_CH-1:0]          sched_beats_done,
    output logic                                  push,
    output chan_id_t                              push_ch,
    output beat_len_t                             push_beats,
    output logic                                  issue_last
);

    // Bytes per beat as the AXI size code
    localparam logic [2:0] SIZE_CODE = 3'($clog2(`WR_DATA_W / 8));

    logic      aw_valid_q;
    chan_id_t  aw_ch_q;
    beat_len_t aw_len_q;
    logic      aw_hs;
    beat_len_t aw_beats;

    assign aw_hs    = aw_valid_q && awready;
    assign aw_beats = aw_len_q + 8'd1;

    // ==========================================================
    // Address command register
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_valid_q <= 1'b0;
        end else if (grant_valid && !aw_valid_q) begin
            aw_valid_q <= 1'b1;
        end else if (aw_hs) begin
            aw_valid_q <= 1'b0;
        end
    end

    // Channel and length are only looked at while awvalid is high
    always_ff @(posedge clk) begin
        if (grant_valid && !aw_valid_q) begin
            aw_ch_q  <= grant_id;
            aw_len_q <= burst_len[grant_id];
        end
    end

    assign awvalid   = aw_valid_q;
    assign awid      = (`WR_ID_W)'(aw_ch_q);
    // Scheduler advances its address after sched_done
    assign awaddr    = sched_addr[aw_ch_q];
    assign awlen     = aw_len_q;
    assign awsize    = SIZE_CODE;
    assign awburst   = `WR_BURST_INCR;
    assign grant_ack = aw_hs;

    // Reserve the burst's data in the buffer on the handshake itself
    always_comb begin
        for (int i = 0; i < `WR_NUM_CH; i++) begin
            drain_req[i]  = aw_hs && (aw_ch_q == chan_id_t'(i));
            drain_size[i] = drain_req[i] ? aw_beats : '0;
        end
    end

    // ==========================================================
    // Burst-issued strobe to the scheduler
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sched_done <= '0;
        end else begin
            sched_done <= '0;
            if (aw_hs) begin
                sched_done[aw_ch_q] <= 1'b1;
            end
        end
    end

    // Count held until the channel issues again
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            sched_beats_done[aw_ch_q] <= beat_total_t'(aw_len_q) + 32'd1;
        end
    end

    // Hand the burst to the W stream and the response tracker
    assign push       = aw_hs;
    assign push_ch    = aw_ch_q;
    assign push_beats = aw_beats;
    // Nothing left after this burst
    assign issue_last = sched_beats[aw_ch_q] <= beat_total_t'(aw_len_q) + 32'd1;

endmodule

//--- verilog/wr_w_stream.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_w_stream
    import wr_engine_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  chan_id_t                   push_ch,
    input  beat_len_t                  push_beats,
    input  logic [`WR_NUM_CH-1:0]      sram_valid,
    input  logic [`WR_DATA_W-1:0]      sram_data,
    input  logic                       wready,
    output logic                       sram_drain,
    output chan_id_t                   sram_id,
    output logic [`WR_DATA_W-1:0]      wdata,
    output logic [`WR_DATA_W/8-1:0]    wstrb,
    output logic                       wlast,
    output logic                       wvalid
);

    localparam int PTR_W = $clog2(`WR_ORDER_DEPTH);

    // ==========================================================
    // Order queue, one entry per issued burst
    // ==========================================================
    chan_id_t   q_ch    [`WR_ORDER_DEPTH];
    beat_len_t  q_beats [`WR_ORDER_DEPTH];
    // Wrap bit on top tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           q_empty;

    // Burst on the bus
    logic      active;
    chan_id_t  cur_ch;
    beat_len_t cur_cnt;

    logic beat_hs;
    logic end_burst;
    logic load;

    assign q_empty   = (wr_ptr == rd_ptr);
    assign beat_hs   = wvalid && wready;
    assign end_burst = beat_hs && wlast;
    // Take the next burst when idle or right on the closing beat
    assign load      = !q_empty && (!active || end_burst);

    always_ff @(posedge clk) begin
        if (push) begin
            q_ch[wr_ptr[PTR_W-1:0]]    <= push_ch;
            q_beats[wr_ptr[PTR_W-1:0]] <= push_beats;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ==========================================================
    // Beat counter
    // ==========================================================
    // Counts down to 1; a loaded 0 stands for 256 beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            cur_ch  <= '0;
            cur_cnt <= '0;
        end else if (load) begin
            active  <= 1'b1;
            cur_ch  <= q_ch[rd_ptr[PTR_W-1:0]];
            cur_cnt <= q_beats[rd_ptr[PTR_W-1:0]];
        end else if (end_burst) begin
            active  <= 1'b0;
        end else if (beat_hs) begin
            cur_cnt <= cur_cnt - 8'd1;
        end
    end

    // Buffer data goes straight to the bus
    assign sram_drain = active && wready;
    assign sram_id    = cur_ch;
    assign wvalid     = active && sram_valid[cur_ch];
    assign wdata      = sram_data;
    assign wstrb      = '1;
    assign wlast      = active && (cur_cnt == 8'd1);

endmodule

//--- verilog/wr_resp_tracker.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_resp_tracker
    import wr_engine_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  chan_id_t              push_ch,
    input  beat_len_t             push_beats,
    input  logic                  issue_last,
    input  logic [`WR_ID_W-1:0]   bid,
    input  logic [1:0]            bresp,
    input  logic                  bvalid,
    output logic                  bready,
    output logic [`WR_NUM_CH-1:0] busy,
    output logic [`WR_NUM_CH-1:0] sched_ready,
    output logic [`WR_NUM_CH-1:0] sched_error
);

    // Per-channel record of the one burst in flight
    // Beats waiting on a response, zero when idle
    logic [$bits(beat_len_t):0] pend   [`WR_NUM_CH];
    logic [`WR_NUM_CH-1:0]      last_q;

    logic [`WR_NUM_CH-1:0] b_hit;
    logic [`WR_NUM_CH-1:0] issue_hit;

    // Every response is taken at once
    assign bready = 1'b1;

    always_comb begin
        for (int i = 0; i < `WR_NUM_CH; i++) begin
            b_hit[i]     = bvalid && (chan_id_t'(bid) == chan_id_t'(i));
            issue_hit[i] = push && (push_ch == chan_id_t'(i));
            busy[i]      = (pend[i] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WR_NUM_CH; i++) begin
                pend[i] <= '0;
            end
            last_q      <= '0;
            sched_ready <= '0;
            sched_error <= '0;
        end else begin
            sched_ready <= '0;
            for (int i = 0; i < `WR_NUM_CH; i++) begin
                if (b_hit[i]) begin
                    pend[i] <= '0;
                end
                // A new issue overrides the clear in the same cycle
                if (issue_hit[i]) begin
                    pend[i]   <= {push_beats == '0, push_beats};
                    last_q[i] <= issue_last;
                end
                // Descriptor finished once its tail burst is answered
                if (b_hit[i] && busy[i] && last_q[i]) begin
                    sched_ready[i] <= 1'b1;
                end
                // Sticky until reset
                if (b_hit[i] && (bresp != `WR_RESP_OKAY)) begin
                    sched_error[i] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/wr_engine_top.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_engine_top (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // ==========================================================
    // Configuration and schedulers
    // ==========================================================
    input  logic [7:0]                            cfg_xfer_len,
    input  logic [`WR_NUM_CH-1:0]                 sched_valid,
    input  logic [`WR_NUM_CH-1:0][`WR_ADDR_W-1:0] sched_addr,
    input  logic [`WR_NUM_CH-1:0][31:0]           sched_beats,
    output logic [`WR_NUM_CH-1:0]                 sched_ready,
    output logic [`WR_NUM_CH-1:0]                 sched_done,
    output logic [`WR_NUM_CH-1:0][31:0]           sched_beats_done,
    output logic [`WR_NUM_CH-1:0]                 sched_error,

    // Buffer controller
    output logic [`WR_NUM_CH-1:0]                 drain_req,
    output logic [`WR_NUM_CH-1:0][7:0]            drain_size,
    input  logic [`WR_NUM_CH-1:0][`WR_CNT_W-1:0]  data_avail,
    input  logic [`WR_NUM_CH-1:0]                 sram_valid,
    output logic                                  sram_drain,
    output logic [$clog2(`WR_NUM_CH)-1:0]         sram_id,
    input  logic [`WR_DATA_W-1:0]                 sram_data,

    // ==========================================================
    // AXI write
    // ==========================================================
    output logic [`WR_ID_W-1:0]                   awid,
    output logic [`WR_ADDR_W-1:0]                 awaddr,
    output logic [7:0]                            awlen,
    output logic [2:0]                            awsize,
    output logic [1:0]                            awburst,
    output logic                                  awvalid,
    input  logic                                  awready,
    output logic [`WR_DATA_W-1:0]                 wdata,
    output logic [`WR_DATA_W/8-1:0]               wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    input  logic                                  wready,
    input  logic [`WR_ID_W-1:0]                   bid,
    input  logic [1:0]                            bresp,
    input  logic                                  bvalid,
    output logic                                  bready
);

    // Filter and arbiter
    logic [`WR_NUM_CH-1:0]             req;
    logic [`WR_NUM_CH-1:0][7:0]        burst_len;
    logic [`WR_NUM_CH-1:0]             busy;
    logic                              grant_valid;
    logic [$clog2(`WR_NUM_CH)-1:0]     grant_id;
    logic                              grant_ack;

    // Issued burst, fanned out to W stream and tracker
    logic                              push;
    logic [$clog2(`WR_NUM_CH)-1:0]     push_ch;
    logic [7:0]                        push_beats;
    logic                              issue_last;

    wr_req_filter u_wr_req_filter (
        .sched_valid  (sched_valid),
        .sched_beats  (sched_beats),
        .cfg_xfer_len (cfg_xfer_len),
        .data_avail   (data_avail),
        .busy         (busy),
        .req          (req),
        .burst_len    (burst_len)
    );

    wr_rr_arbiter u_wr_rr_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .grant_ack   (grant_ack),
        .grant_valid (grant_valid),
        .grant_id    (grant_id)
    );

    wr_aw_issue u_wr_aw_issue (
        .clk              (clk),
        .rst_n            (rst_n),
        .grant_valid      (grant_valid),
        .grant_id         (grant_id),
        .burst_len        (burst_len),
        .sched_addr       (sched_addr),
        .sched_beats      (sched_beats),
        .awready          (awready),
        .awid             (awid),
        .awaddr           (awaddr),
        .awlen            (awlen),
        .awsize           (awsize),
        .awburst          (awburst),
        .awvalid          (awvalid),
        .grant_ack        (grant_ack),
        .drain_req        (drain_req),
        .drain_size       (drain_size),
        .sched_done       (sched_done),
        .sched_beats_done (sched_beats_done),
        .push             (push),
        .push_ch          (push_ch),
        .push_beats       (push_beats),
        .issue_last       (issue_last)
    );

    wr_w_stream u_wr_w_stream (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_ch    (push_ch),
        .push_beats (push_beats),
        .sram_valid (sram_valid),
        .sram_data  (sram_data),
        .wready     (wready),
        .sram_drain (sram_drain),
        .sram_id    (sram_id),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid)
    );

    wr_resp_tracker u_wr_resp_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_ch     (push_ch),
        .push_beats  (push_beats),
        .issue_last  (issue_last),
        .bid         (bid),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .busy        (busy),
        .sched_ready (sched_ready),
        .sched_error (sched_error)
    );

endmodule

//--- verification/wr_engine_tb.sv
`timescale 1ns/1ps

`include "wr_engine_config.svh"

module wr_engine_tb;

    localparam int NCH         = `WR_NUM_CH;
    localparam int BEAT_BYTES  = `WR_DATA_W / 8;
    localparam int TEST_CYCLES = 6000;
    localparam int GATE_CYCLES = 60;

    logic                            clk;
    logic                            rst_n;
    logic [7:0]                      cfg_xfer_len;
    logic [NCH-1:0]                  sched_valid;
    logic [NCH-1:0][`WR_ADDR_W-1:0]  sched_addr;
    logic [NCH-1:0][31:0]            sched_beats;
    logic [NCH-1:0]                  sched_ready;
    logic [NCH-1:0]                  sched_done;
    logic [NCH-1:0][31:0]            sched_beats_done;
    logic [NCH-1:0]                  sched_error;
    logic [NCH-1:0]                  drain_req;
    logic [NCH-1:0][7:0]             drain_size;
    logic [NCH-1:0][`WR_CNT_W-1:0]   data_avail;
    logic [NCH-1:0]                  sram_valid;
    logic                            sram_drain;
    logic [$clog2(NCH)-1:0]          sram_id;
    logic [`WR_DATA_W-1:0]           sram_data;
    logic [`WR_ID_W-1:0]             awid;
    logic [`WR_ADDR_W-1:0]           awaddr;
    logic [7:0]                      awlen;
    logic [2:0]                      awsize;
    logic [1:0]                      awburst;
    logic                            awvalid;
    logic                            awready;
    logic [`WR_DATA_W-1:0]           wdata;
    logic [`WR_DATA_W/8-1:0]         wstrb;
    logic                            wlast;
    logic                            wvalid;
    logic                            wready;
    logic [`WR_ID_W-1:0]             bid;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;

    // Reference state kept by the models
    int             errors;
    int             exp_rem [NCH];
    int             ready_cnt [NCH];
    int             rd_cnt [NCH];
    int             data_cnt [NCH];
    logic [NCH-1:0] last_flag;
    logic [NCH-1:0] exp_done;
    logic [NCH-1:0] exp_ready;
    logic [NCH-1:0] exp_err;
    logic [NCH-1:0] sched_upd;
    int             done_ch;
    int             done_beats;
    int             upd_beats;
    int             wq_ch[$];
    int             wq_beats[$];
    int             bq[$];
    int             w_idx;
    int             last_aw;
    int             arb_left;
    int             test_ch;
    logic [1:0]     cur_resp;

    wr_engine_top u_wr_engine_top (.*);

    always #20 clk = ~clk;

    // Buffer word for a channel and its running beat index
    function automatic logic [31:0] buffer_word(int ch, int idx);
        return {8'hc0 + 8'(ch), 24'(idx)};
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ==========================================================
    // Scheduler, buffer and AXI slave models with the monitors
    // ==========================================================
    always @(posedge clk) begin : bus_model
        int c;
        int exp_len;

        // Registered outputs against what last cycle predicted
        check_value("sched_done", sched_done, exp_done);
        if (exp_done != '0) begin
            check_value("sched_beats_done", sched_beats_done[done_ch], done_beats);
        end
        check_value("sched_ready", sched_ready, exp_ready);
        check_value("sched_error", sched_error, exp_err);
        for (c = 0; c < NCH; c++) begin
            if (sched_ready[c]) begin
                ready_cnt[c]++;
            end
        end
        sched_upd = exp_done;
        upd_beats = done_beats;
        exp_done  = '0;
        exp_ready = '0;

        // AW handshake with the length expected from the remaining beats
        if (awvalid && awready) begin
            // Channel under test is known unless all four run at once
            if (test_ch < NCH) begin
                c = test_ch;
                check_value("awid", awid, c);
            end else begin
                c = int'(awid[1:0]);
                check_value("awid high bits", awid >> $clog2(NCH), 0);
            end
            assert (exp_rem[c] > 0) else begin
                $display("%0t: burst issued on channel %0d with nothing to send", $time, c);
                errors++;
            end
            if (exp_rem[c] > 0) begin
                exp_len = (exp_rem[c] > cfg_xfer_len + 1) ? cfg_xfer_len : exp_rem[c] - 1;
                check_value("awlen", awlen, exp_len);
                check_value("awaddr", awaddr, sched_addr[c]);
                check_value("awsize", awsize, $clog2(BEAT_BYTES));
                check_value("awburst", awburst, `WR_BURST_INCR);
                check_value("drain_req", drain_req, 1 << c);
                check_value("drain_size", drain_size[c], 8'(exp_len + 1));
                // Grants go round in turn while every channel starts fresh
                if (arb_left > 0) begin
                    check_value("awid order", c, (last_aw + 1) % NCH);
                    arb_left--;
                end
                exp_rem[c] -= exp_len + 1;
                last_flag[c] = (exp_rem[c] == 0);
                exp_done[c] = 1'b1;
                done_ch     = c;
                done_beats  = exp_len + 1;
                wq_ch.push_back(c);
                wq_beats.push_back(exp_len + 1);
            end
            last_aw = c;
        end

        // W beats follow the address order
        if (wvalid && wready) begin
            assert (wq_ch.size() > 0) else begin
                $display("%0t: write beat with no burst issued", $time);
                errors++;
            end
            if (wq_ch.size() > 0) begin
                c = wq_ch[0];
                check_value("wdata", wdata, buffer_word(c, data_cnt[c]));
                check_value("wlast", wlast, w_idx == wq_beats[0] - 1);
                check_value("wstrb", wstrb, 4'hf);
                data_cnt[c]++;
                w_idx++;
                if (w_idx == wq_beats[0]) begin
                    w_idx = 0;
                    bq.push_back(c);
                    void'(wq_ch.pop_front());
                    void'(wq_beats.pop_front());
                end
            end
        end

        // Buffer read pointer per channel
        if (sram_drain && sram_valid[sram_id]) begin
            rd_cnt[sram_id]++;
        end

        // Ready expected only when the descriptor's tail is answered
        if (bvalid) begin
            check_value("bready", bready, 1);
            c = int'(bid[1:0]);
            exp_ready[c] = last_flag[c];
            if (bresp != `WR_RESP_OKAY) begin
                exp_err[c] = 1'b1;
            end
        end

        #2;
        awready = ($urandom % 4) != 0;
        wready  = ($urandom % 3) != 0;
        bvalid  = 1'b0;
        if (bq.size() > 0 && ($urandom % 2) == 0) begin
            bvalid = 1'b1;
            bid    = `WR_ID_W'(bq.pop_front());
            bresp  = cur_resp;
        end
        sram_data = buffer_word(sram_id, rd_cnt[sram_id]);
        // Scheduler steps past each issued burst
        for (c = 0; c < NCH; c++) begin
            if (sched_upd[c]) begin
                sched_beats[c] = sched_beats[c] - upd_beats;
                sched_addr[c]  = sched_addr[c] + upd_beats * BEAT_BYTES;
                if (sched_beats[c] == 0) begin
                    sched_valid[c] = 1'b0;
                end
            end
        end
    end

    // One descriptor per channel in the range or a gating window
    task automatic run_test(input int ch, input int total, input int avail, input int len,
                            input int resp, output bit timed_out);
        int first;
        int last;
        int cycles;
        bit gated;
        bit done;

        timed_out = 0;
        first = (ch == NCH) ? 0 : ch;
        last  = (ch == NCH) ? NCH - 1 : ch;
        // Short of a full burst and more bursts to come
        gated = (total > len + 1) && (avail < len + 1);
        @(posedge clk);
        #2;
        cfg_xfer_len = 8'(len);
        cur_resp     = 2'(resp);
        test_ch      = ch;
        arb_left     = (ch == NCH) ? NCH : 0;
        for (int c = first; c <= last; c++) begin
            data_avail[c]  = `WR_CNT_W'(avail);
            sched_addr[c]  = 32'h1000_0000 + c * 32'h0100_0000;
            sched_beats[c] = total;
            sched_valid[c] = 1'b1;
            exp_rem[c]     = gated ? 0 : total;
            ready_cnt[c]   = 0;
        end
        if (gated) begin
            for (cycles = 0; cycles < GATE_CYCLES; cycles++) begin
                @(negedge clk);
                assert (!awvalid) else begin
                    $display("%0t: burst started without enough buffered data", $time);
                    errors++;
                end
            end
            @(posedge clk);
            #2;
            for (int c = first; c <= last; c++) begin
                sched_valid[c] = 1'b0;
            end
        end else begin
            done   = 0;
            cycles = 0;
            while (!done && cycles < TEST_CYCLES) begin
                @(negedge clk);
                cycles++;
                done = 1;
                for (int c = first; c <= last; c++) begin
                    if (ready_cnt[c] == 0) begin
                        done = 0;
                    end
                end
            end
            assert (done) else begin
                $display("%0t: timeout waiting for sched_ready", $time);
                errors++;
                timed_out = 1;
            end
            // Quiet cycles to catch a second ready pulse
            repeat (8) @(negedge clk);
            for (int c = first; c <= last; c++) begin
                check_value("sched_ready pulses", ready_cnt[c], 1);
                check_value("beats left", exp_rem[c], 0);
            end
        end
    endtask

    initial begin : main
        int    fd;
        int    n;
        int    tests;
        int    bad_tests;
        int    err_before;
        int    t_ch;
        int    t_total;
        int    t_avail;
        int    t_len;
        int    t_resp;
        bit    timed_out;
        string line;

        void'($urandom(32'h5ef33c4d));
        clk          = 1'b0;
        rst_n        = 1'b0;
        cfg_xfer_len = '0;
        sched_valid  = '0;
        sched_addr   = '0;
        sched_beats  = '0;
        data_avail   = '0;
        sram_valid   = '1;
        sram_data    = '0;
        awready      = 1'b0;
        wready       = 1'b0;
        bid          = '0;
        bresp        = '0;
        bvalid       = 1'b0;
        errors       = 0;
        tests        = 0;
        bad_tests    = 0;
        timed_out    = 0;
        last_flag    = '0;
        exp_done     = '0;
        exp_ready    = '0;
        exp_err      = '0;
        sched_upd    = '0;
        done_ch      = 0;
        done_beats   = 0;
        upd_beats    = 0;
        w_idx        = 0;
        arb_left     = 0;
        test_ch      = 0;
        cur_resp     = '0;
        // Channel 0 wins the first grant after reset
        last_aw      = NCH - 1;
        for (int c = 0; c < NCH; c++) begin
            exp_rem[c]   = 0;
            ready_cnt[c] = 0;
            rd_cnt[c]    = 0;
            data_cnt[c]  = 0;
        end

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("awvalid", awvalid, 0);
        check_value("wvalid", wvalid, 0);
        check_value("drain_req", drain_req, 0);

        fd = $fopen("verification/wr_engine_testdata.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the test data file");
            errors++;
        end
        if (fd != 0) begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %d %d %d %d", t_ch, t_total, t_avail, t_len, t_resp);
                if (n != 5) begin
                    continue;
                end
                err_before = errors;
                run_test(t_ch, t_total, t_avail, t_len, t_resp, timed_out);
                tests++;
                if (errors != err_before) begin
                    bad_tests++;
                end
                $display("test %0d ch %0d beats %0d burst %0d bresp %0d: %s", tests, t_ch,
                         t_total, t_len + 1, t_resp, (errors == err_before) ? "ok" : "errors");
            end
            $fclose(fd);
        end

        $display("tests run %0d, tests with errors %0d, errors %0d", tests, bad_tests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/wr_engine_pkg.sv
verilog/wr_req_filter.sv
verilog/wr_rr_arbiter.sv
verilog/wr_aw_issue.sv
verilog/wr_w_stream.sv
verilog/wr_resp_tracker.sv
verilog/wr_engine_top.sv
verification/wr_engine_tb.sv

//--- Bender.yml
package:
  name: wr_engine

export_include_dirs:
  - verilog

sources:
  - verilog/wr_engine_pkg.sv
  - verilog/wr_req_filter.sv
  - verilog/wr_rr_arbiter.sv
  - verilog/wr_aw_issue.sv
  - verilog/wr_w_stream.sv
  - verilog/wr_resp_tracker.sv
  - verilog/wr_engine_top.sv
  - target: test
    files:
      - verification/wr_engine_tb.sv

//--- verification/wr_engine_testdata.txt
# Columns: channel (4 = all four channels at once), total beats, data available,
# cfg_xfer_len (burst length minus one), bresp
0 16 255 3 0
1 10 255 3 0
2 3 0 7 0
3 20 8 7 0
1 12 2 3 0
2 5 255 0 0
3 8 255 7 2
0 40 255 15 0
1 300 200 255 0
0 256 255 255 0
4 4 255 3 0
4 8 255 1 0
2 9 255 3 3
4 6 255 2 0
